//--- bench/spu_alu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module spu_alu_assert #(
    parameter int DATA_BITS = 8
) (
    input wire logic                 clk,
    input wire logic                 rst_n,
    input wire logic                 cke,
    input wire logic [DATA_BITS-1:0] result,
    input wire logic                 result_valid
);

    int assert_errors = 0;  // read by the testbench at the end

    a_idle_in_reset: assert property (@(posedge clk) !rst_n |-> !result_valid)
        else begin
            $error("result_valid high during reset");
            assert_errors++;
        end

    a_valid_known: assert property (@(posedge clk) !$isunknown(result_valid))
        else begin
            $error("result_valid is unknown");
            assert_errors++;
        end

    // a frozen pipe must not move its outputs
    a_freeze: assert property (@(posedge clk) disable iff (!rst_n)
        !$past(cke) |-> $stable(result) && $stable(result_valid))
        else begin
            $error("output changed while cke was low");
            assert_errors++;
        end

endmodule

bind spu_alu_top spu_alu_assert #(.DATA_BITS(DATA_BITS)) i_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .cke          (cke),
    .result       (result),
    .result_valid (result_valid)
);

`default_nettype wire

//--- bench/spu_alu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module spu_alu_checker #(
    parameter int DATA_BITS = 8
) (
    input wire logic                 clk,
    input wire logic                 rst_n,
    input wire logic                 cke,
    input wire logic                 clear,
    input wire logic [DATA_BITS-1:0] result,
    input wire logic                 result_valid
);

    logic [DATA_BITS-1:0] exp_q   [$];
    string                name_q  [$];
    bit                   check_q [$];
    bit                   last_q  [$];
    int                   pass_count  = 0;
    int                   fail_count  = 0;
    int                   error_count = 0;
    int                   test_errs   = 0;
    bit                   cke_q       = 1'b0;  // output moved on last edge
    bit                   clear_q     = 1'b0;
    logic [DATA_BITS-1:0] exp_val;
    string                exp_name;
    bit                   exp_check;
    bit                   exp_last;

    task automatic push_expected(string name, logic [DATA_BITS-1:0] value,
                                 bit checked, bit last);
        name_q.push_back(name);
        exp_q.push_back(value);
        check_q.push_back(checked);
        last_q.push_back(last);
    endtask

    function automatic int pending_checked();
        int n;
        n = 0;
        foreach (check_q[i]) begin
            if (check_q[i]) n++;
        end
        return n;
    endfunction

    task automatic report_leftover();
        if (pending_checked() > 0) begin
            $display("%0d expected results never came out of the DUT", pending_checked());
            error_count++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            cke_q   = 1'b0;
            clear_q = 1'b0;
        end else begin
            if (clear_q && (result !== '0 || result_valid !== 1'b0)) begin
                $display("result not zero and idle after clear, got %h valid %b",
                         result, result_valid);
                test_errs++;
            end
            if (result_valid === 1'b1 && cke_q) begin
                if (exp_q.size() == 0) begin
                    $display("result_valid high with no expected result queued");
                    error_count++;
                end else begin
                    exp_val   = exp_q.pop_front();
                    exp_name  = name_q.pop_front();
                    exp_check = check_q.pop_front();
                    exp_last  = last_q.pop_front();
                    if (exp_check && result !== exp_val) begin
                        $display("Fail %s: expected %h, actual %h", exp_name, exp_val, result);
                        test_errs++;
                    end
                    if (exp_last) begin
                        if (test_errs == 0) begin
                            $display("test %s passed", exp_name);
                            pass_count++;
                        end else begin
                            $display("test %s failed", exp_name);
                            fail_count++;
                        end
                        test_errs = 0;
                    end
                end
            end
            if (cke && clear) begin  // pipe contents are lost
                foreach (check_q[i]) begin
                    if (check_q[i]) begin
                        $display("clear discarded a pending result of %s", name_q[i]);
                        error_count++;
                    end
                end
                exp_q.delete();
                name_q.delete();
                check_q.delete();
                last_q.delete();
            end
            clear_q = cke && clear;
            cke_q   = cke;
        end
    end

endmodule

`default_nettype wire

//--- bench/spu_alu_trace.txt
# kind name we opcode a b expected, hex values
# kind V pair, L last pair of test, F flush pair, W opcode write, C clear, K cke low
V pass 0 0 12 34 12
V pass 0 0 a5 ff a5
L pass 0 0 3c 00 3c
F pass 0 0 00 00 00
F pass 0 0 00 00 00
W not 1 1 00 00 00
V not 0 0 ff 00 00
V not 0 0 00 ff ff
L not 0 0 55 aa aa
F not 0 0 00 00 00
F not 0 0 00 00 00
W logic 1 2 00 00 00
V logic 0 0 ff ff ff
V logic 0 0 55 aa 00
V logic 0 0 00 ff 00
V logic 1 3 f0 3c 30
V logic 0 0 55 aa ff
V logic 1 4 00 00 00
V logic 0 0 ff aa 55
L logic 0 0 a5 a5 00
F logic 0 0 00 00 00
F logic 0 0 00 00 00
W arith 1 5 00 00 00
V arith 0 0 ff 01 00
V arith 0 0 7f 01 80
V arith 1 6 12 34 46
V arith 0 0 00 01 ff
L arith 0 0 80 01 7f
F arith 0 0 00 00 00
F arith 0 0 00 00 00
V align 1 0 10 20 f0
V align 1 1 33 00 33
V align 1 2 0f 00 f0
V align 1 4 6c 3a 28
V align 1 5 6c 3a 56
L align 0 0 80 90 10
F align 0 0 00 00 00
F align 0 0 00 00 00
C clear_cke 0 0 00 00 00
V clear_cke 0 0 01 02 03
V clear_cke 0 0 10 10 20
K clear_cke 0 0 00 00 00
K clear_cke 0 0 00 00 00
K clear_cke 0 0 00 00 00
V clear_cke 0 0 40 01 41
L clear_cke 0 0 fe 03 01
F clear_cke 0 0 00 00 00
F clear_cke 0 0 00 00 00

//--- bench/tb_spu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spu_alu;

    localparam int DATA_BITS = 8;
    localparam int LATENCY   = 2;

    logic                 clk;
    logic                 rst_n;
    logic                 cke;
    logic [DATA_BITS-1:0] a;
    logic [DATA_BITS-1:0] b;
    logic                 clear;
    logic                 valid;
    logic                 cfg_we;
    logic [2:0]           cfg_opcode;
    logic [DATA_BITS-1:0] result;
    logic                 result_valid;

    string                rec_kind [$];
    string                rec_name [$];
    logic                 rec_we   [$];
    logic [2:0]           rec_op   [$];
    logic [DATA_BITS-1:0] rec_a    [$];
    logic [DATA_BITS-1:0] rec_b    [$];
    logic [DATA_BITS-1:0] rec_exp  [$];
    int                   cycle_count;
    int                   cycle_limit;
    int                   idle_cycles;

    spu_alu_top #(.DATA_BITS(DATA_BITS), .LATENCY(LATENCY)) i_spu_alu_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .cke          (cke),
        .a            (a),
        .b            (b),
        .clear        (clear),
        .valid        (valid),
        .cfg_we       (cfg_we),
        .cfg_opcode   (cfg_opcode),
        .result       (result),
        .result_valid (result_valid)
    );

    spu_alu_checker #(.DATA_BITS(DATA_BITS)) i_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .cke          (cke),
        .clear        (clear),
        .result       (result),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, results still missing", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    task automatic read_trace();
        int                   fd;
        int                   n;
        string                line;
        string                kind;
        string                name;
        logic                 we;
        logic [2:0]           op;
        logic [DATA_BITS-1:0] va;
        logic [DATA_BITS-1:0] vb;
        logic [DATA_BITS-1:0] ve;
        fd = $fopen("bench/spu_alu_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%s %s %h %h %h %h %h", kind, name, we, op, va, vb, ve);
                    if (n == 7) begin
                        rec_kind.push_back(kind);
                        rec_name.push_back(name);
                        rec_we.push_back(we);
                        rec_op.push_back(op);
                        rec_a.push_back(va);
                        rec_b.push_back(vb);
                        rec_exp.push_back(ve);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_idle();
        cke        = 1'b1;
        valid      = 1'b0;
        clear      = 1'b0;
        cfg_we     = 1'b0;
        cfg_opcode = '0;
        a          = '0;
        b          = '0;
    endtask

    task automatic apply_record(int i);
        drive_idle();
        case (rec_kind[i])
            "W": begin
                cfg_we     = 1'b1;
                cfg_opcode = rec_op[i];
            end
            "C": clear = 1'b1;
            "K": cke = 1'b0;
            default: begin  // V, L or F pair
                valid      = 1'b1;
                a          = rec_a[i];
                b          = rec_b[i];
                cfg_we     = rec_we[i];
                cfg_opcode = rec_op[i];
                i_checker.push_expected(rec_name[i], rec_exp[i],
                                        rec_kind[i] != "F", rec_kind[i] == "L");
            end
        endcase
    endtask

    initial begin
        cycle_count = 0;
        cycle_limit = 1000000;
        rst_n       = 1'b1;
        drive_idle();
        void'($urandom(74));
        read_trace();
        cycle_limit = rec_kind.size() + 4 * LATENCY + 50;
        #5 rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #2 rst_n = 1'b1;
        for (int i = 0; i < rec_kind.size(); i++) begin
            if (i > 0 && rec_name[i] != rec_name[i-1]) begin
                idle_cycles = $urandom % 4;
                repeat (idle_cycles) begin
                    @(posedge clk);
                    #2 drive_idle();
                end
            end
            @(posedge clk);
            #2 apply_record(i);
        end
        @(posedge clk);
        #2 drive_idle();
        while (i_checker.pending_checked() > 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        i_checker.report_leftover();
        $display("tests passed %0d, tests failed %0d, other errors %0d, assertion failures %0d",
                 i_checker.pass_count, i_checker.fail_count, i_checker.error_count,
                 i_spu_alu_top.i_assert.assert_errors);
        if (i_checker.fail_count == 0 && i_checker.error_count == 0
                && i_spu_alu_top.i_assert.assert_errors == 0
                && i_checker.pass_count > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
rtl/spu_pkg.sv
rtl/spu_operand_if.sv
rtl/spu_op_nop.sv
rtl/spu_op_not.sv
rtl/spu_op_logic.sv
rtl/spu_op_addsub.sv
rtl/spu_cfg_regs.sv
rtl/spu_alu_top.sv
bench/spu_alu_checker.sv
bench/spu_alu_assert.sv
bench/tb_spu_alu.sv

//--- rtl/spu_alu_top.sv
`timescale 1ns/1ps
`default_nettype none

module spu_alu_top
    import spu_pkg::*;
    #(
        parameter int DATA_BITS = DEF_DATA_BITS,
        parameter int LATENCY   = DEF_LATENCY
    )
    (
        input  var logic                   clk,
        input  var logic                   rst_n,
        input  var logic                   cke,

        input  var logic [DATA_BITS-1:0]   a,
        input  var logic [DATA_BITS-1:0]   b,
        input  var logic                   clear,
        input  var logic                   valid,

        input  var logic                   cfg_we,
        input  var logic [OPCODE_BITS-1:0] cfg_opcode,

        output var logic [DATA_BITS-1:0]   result,
        output var logic                   result_valid
    );

    spu_opcode_e          cfg_op;
    spu_opcode_e          op_aligned;
    logic [DATA_BITS-1:0] pass_data;
    logic [DATA_BITS-1:0] not_data;
    logic [DATA_BITS-1:0] and_data;
    logic [DATA_BITS-1:0] or_data;
    logic [DATA_BITS-1:0] xor_data;
    logic [DATA_BITS-1:0] add_data;
    logic [DATA_BITS-1:0] sub_data;

    spu_operand_if #(.DATA_BITS(DATA_BITS)) opnd ();

    assign opnd.a     = a;
    assign opnd.b     = b;
    assign opnd.clear = clear;
    assign opnd.valid = valid;

    assign cfg_op = spu_opcode_e'(cfg_opcode);

    spu_cfg_regs #(.LATENCY(LATENCY)) i_cfg_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .cke        (cke),
        .cfg_we     (cfg_we),
        .cfg_opcode (cfg_op),
        .valid      (valid),
        .clear      (clear),
        .op_aligned (op_aligned)
    );

    // pass-a path, also the source of result_valid
    spu_op_nop #(.LATENCY(LATENCY), .DATA_BITS(DATA_BITS)) i_pass_a (
        .clk     (clk),
        .rst_n   (rst_n),
        .cke     (cke),
        .s_data  (a),
        .s_clear (clear),
        .s_valid (valid),
        .m_data  (pass_data),
        .m_valid (result_valid)
    );

    spu_op_not #(.LATENCY(LATENCY), .DATA_BITS(DATA_BITS)) i_not (
        .clk(clk), .rst_n(rst_n), .cke(cke), .opnd(opnd), .m_data(not_data)
    );

    spu_op_logic #(.LATENCY(LATENCY), .DATA_BITS(DATA_BITS), .FN(FN_AND)) i_and (
        .clk(clk), .rst_n(rst_n), .cke(cke), .opnd(opnd), .m_data(and_data)
    );

    spu_op_logic #(.LATENCY(LATENCY), .DATA_BITS(DATA_BITS), .FN(FN_OR)) i_or (
        .clk(clk), .rst_n(rst_n), .cke(cke), .opnd(opnd), .m_data(or_data)
    );

    spu_op_logic #(.LATENCY(LATENCY), .DATA_BITS(DATA_BITS), .FN(FN_XOR)) i_xor (
        .clk(clk), .rst_n(rst_n), .cke(cke), .opnd(opnd), .m_data(xor_data)
    );

    spu_op_addsub #(.LATENCY(LATENCY), .DATA_BITS(DATA_BITS), .SUBTRACT(1'b0)) i_add (
        .clk(clk), .rst_n(rst_n), .cke(cke), .opnd(opnd), .m_data(add_data)
    );

    spu_op_addsub #(.LATENCY(LATENCY), .DATA_BITS(DATA_BITS), .SUBTRACT(1'b1)) i_sub (
        .clk(clk), .rst_n(rst_n), .cke(cke), .opnd(opnd), .m_data(sub_data)
    );

    always_comb begin
        case (op_aligned)
            OP_PASS_A: result = pass_data;
            OP_NOT_A:  result = not_data;
            OP_AND:    result = and_data;
            OP_OR:     result = or_data;
            OP_XOR:    result = xor_data;
            OP_ADD:    result = add_data;
            OP_SUB:    result = sub_data;
            default:   result = '0;  // unknown opcode
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/spu_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module spu_cfg_regs
    import spu_pkg::*;
    #(
        parameter int LATENCY = DEF_LATENCY
    )
    (
        input  var logic        clk,
        input  var logic        rst_n,
        input  var logic        cke,
        input  var logic        cfg_we,
        input  var spu_opcode_e cfg_opcode,
        input  var logic        valid,
        input  var logic        clear,
        output var spu_opcode_e op_aligned
    );

    spu_opcode_e            op_reg;
    logic [OPCODE_BITS-1:0] op_delayed;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_reg <= OP_PASS_A;
        end else if (cke && cfg_we) begin
            op_reg <= cfg_opcode;
        end
    end

    // opcode rides along with its operand pair
    spu_op_nop #(
        .LATENCY    (LATENCY),
        .DATA_BITS  (OPCODE_BITS),
        .CLEAR_DATA (OP_PASS_A)
    ) i_op_pipe (
        .clk     (clk),
        .rst_n   (rst_n),
        .cke     (cke),
        .s_data  (op_reg),
        .s_clear (clear),
        .s_valid (valid),
        .m_data  (op_delayed),
        .m_valid ()
    );

    assign op_aligned = spu_opcode_e'(op_delayed);

endmodule

`default_nettype wire

//--- rtl/spu_op_addsub.sv
`timescale 1ns/1ps
`default_nettype none

module spu_op_addsub
    import spu_pkg::*;
    #(
        parameter int LATENCY   = DEF_LATENCY,
        parameter int DATA_BITS = DEF_DATA_BITS,
        parameter bit SUBTRACT  = 1'b0
    )
    (
        input  var logic                 clk,
        input  var logic                 rst_n,
        input  var logic                 cke,
        spu_operand_if.dst               opnd,
        output var logic [DATA_BITS-1:0] m_data
    );

    logic [DATA_BITS-1:0] b_opnd;
    logic [DATA_BITS-1:0] carry_in;
    logic [DATA_BITS-1:0] sum_data;

    // a - b is a + ~b + 1
    assign b_opnd   = SUBTRACT ? ~opnd.b : opnd.b;
    assign carry_in = {{(DATA_BITS-1){1'b0}}, SUBTRACT};
    assign sum_data = opnd.a + b_opnd + carry_in;  // wraps at data width

    spu_op_nop #(
        .LATENCY   (LATENCY),
        .DATA_BITS (DATA_BITS)
    ) i_delay (
        .clk     (clk),
        .rst_n   (rst_n),
        .cke     (cke),
        .s_data  (sum_data),
        .s_clear (opnd.clear),
        .s_valid (opnd.valid),
        .m_data  (m_data),
        .m_valid ()
    );

endmodule

`default_nettype wire

//--- rtl/spu_op_logic.sv
`timescale 1ns/1ps
`default_nettype none

module spu_op_logic
    import spu_pkg::*;
    #(
        parameter int            LATENCY   = DEF_LATENCY,
        parameter int            DATA_BITS = DEF_DATA_BITS,
        parameter spu_logic_fn_e FN        = FN_AND
    )
    (
        input  var logic                 clk,
        input  var logic                 rst_n,
        input  var logic                 cke,
        spu_operand_if.dst               opnd,
        output var logic [DATA_BITS-1:0] m_data
    );

    logic [DATA_BITS-1:0] fn_data;

    always_comb begin
        case (FN)
            FN_AND:  fn_data = opnd.a & opnd.b;
            FN_OR:   fn_data = opnd.a | opnd.b;
            FN_XOR:  fn_data = opnd.a ^ opnd.b;
            default: fn_data = '0;  // unused encoding
        endcase
    end

    spu_op_nop #(
        .LATENCY   (LATENCY),
        .DATA_BITS (DATA_BITS)
    ) i_delay (
        .clk     (clk),
        .rst_n   (rst_n),
        .cke     (cke),
        .s_data  (fn_data),
        .s_clear (opnd.clear),
        .s_valid (opnd.valid),
        .m_data  (m_data),
        .m_valid ()
    );

endmodule

`default_nettype wire

//--- rtl/spu_op_nop.sv
`timescale 1ns/1ps
`default_nettype none

module spu_op_nop
    import spu_pkg::*;
    #(
        parameter int                   LATENCY    = DEF_LATENCY,
        parameter int                   DATA_BITS  = DEF_DATA_BITS,
        parameter logic [DATA_BITS-1:0] CLEAR_DATA = '0
    )
    (
        input  var logic                 clk,
        input  var logic                 rst_n,
        input  var logic                 cke,

        input  var logic [DATA_BITS-1:0] s_data,
        input  var logic                 s_clear,
        input  var logic                 s_valid,

        output var logic [DATA_BITS-1:0] m_data,
        output var logic                 m_valid
    );

    if (LATENCY < 0) begin : g_bad_latency
        $error("spu_op_nop: LATENCY must not be negative");
    end else if (LATENCY == 0) begin : g_bypass
        assign m_data  = s_data;
        assign m_valid = s_valid & ~s_clear;
    end else begin : g_pipe
        logic [DATA_BITS-1:0] stage_data [LATENCY];
        logic [LATENCY-1:0]   stage_full;  // stage holds a real pair
        logic                 shifted;     // pipe advanced on last edge

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                for (int i = 0; i < LATENCY; i++) begin
                    stage_data[i] <= '0;
                end
                stage_full <= '0;
                shifted    <= 1'b0;
            end else if (cke) begin
                if (s_clear) begin
                    for (int i = 0; i < LATENCY; i++) begin
                        stage_data[i] <= CLEAR_DATA;
                    end
                    stage_full <= '0;
                    shifted    <= 1'b0;
                end else if (s_valid) begin
                    stage_data[0] <= s_data;
                    stage_full[0] <= 1'b1;
                    for (int i = 1; i < LATENCY; i++) begin
                        stage_data[i] <= stage_data[i-1];
                        stage_full[i] <= stage_full[i-1];
                    end
                    shifted <= 1'b1;
                end else begin
                    shifted <= 1'b0;  // hold data, no new result
                end
            end
        end

        assign m_data  = stage_data[LATENCY-1];
        assign m_valid = shifted & stage_full[LATENCY-1];
    end

endmodule

`default_nettype wire

//--- rtl/spu_op_not.sv
`timescale 1ns/1ps
`default_nettype none

module spu_op_not
    import spu_pkg::*;
    #(
        parameter int LATENCY   = DEF_LATENCY,
        parameter int DATA_BITS = DEF_DATA_BITS
    )
    (
        input  var logic                 clk,
        input  var logic                 rst_n,
        input  var logic                 cke,
        spu_operand_if.dst               opnd,
        output var logic [DATA_BITS-1:0] m_data
    );

    logic [DATA_BITS-1:0] not_data;

    assign not_data = ~opnd.a;  // b not used

    spu_op_nop #(
        .LATENCY   (LATENCY),
        .DATA_BITS (DATA_BITS)
    ) i_delay (
        .clk     (clk),
        .rst_n   (rst_n),
        .cke     (cke),
        .s_data  (not_data),
        .s_clear (opnd.clear),
        .s_valid (opnd.valid),
        .m_data  (m_data),
        .m_valid ()
    );

endmodule

`default_nettype wire

//--- rtl/spu_operand_if.sv
`timescale 1ns/1ps
`default_nettype none

interface spu_operand_if
    import spu_pkg::*;
    #(
        parameter int DATA_BITS = DEF_DATA_BITS
    )
    ();

    logic [DATA_BITS-1:0] a;
    logic [DATA_BITS-1:0] b;
    logic                 clear;  // one-cycle pulse
    logic                 valid;  // one cycle per operand pair

    modport src (output a, b, clear, valid);
    modport dst (input a, b, clear, valid);

endinterface

`default_nettype wire

//--- rtl/spu_pkg.sv
`default_nettype none

package spu_pkg;

    localparam int DEF_DATA_BITS = 8;
    localparam int DEF_LATENCY   = 2;
    localparam int OPCODE_BITS   = 3;

    // operand and result word at the default width
    typedef logic [DEF_DATA_BITS-1:0] spu_word_t;

    typedef enum logic [OPCODE_BITS-1:0] {
        OP_PASS_A = 3'd0,
        OP_NOT_A  = 3'd1,
        OP_AND    = 3'd2,
        OP_OR     = 3'd3,
        OP_XOR    = 3'd4,
        OP_ADD    = 3'd5,
        OP_SUB    = 3'd6     // 3'd7 left unused
    } spu_opcode_e;

    typedef enum logic [1:0] {
        FN_AND = 2'd0,
        FN_OR  = 2'd1,
        FN_XOR = 2'd2
    } spu_logic_fn_e;

endpackage

`default_nettype wire
